//--- Makefile
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module tb_cpu -f sim.f -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vtb_cpu

clean:
	rm -rf $(OBJ_DIR)

//--- bench/cpu_bus_assert.sv
`timescale 1ns/10ps

module cpu_bus_assert import cpu_pkg::*; (
  input logic     i_clk,
  input logic     i_reset,
  input logic     i_aw_valid,
  input axil_aw_t i_aw,
  input logic     i_aw_ready,
  input logic     i_w_valid,
  input axil_w_t  i_w,
  input logic     i_w_ready,
  input logic     i_ar_valid,
  input axil_ar_t i_ar,
  input logic     i_ar_ready,
  input logic     i_b_ready,
  input logic     i_r_ready,
  input logic     i_halted,
  input logic     i_fault
);

  // a request channel keeps valid and payload until ready
  aw_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_aw_valid && !i_aw_ready) |=> (i_aw_valid && $stable(i_aw)))
    else $error("aw valid dropped or payload changed before ready");

  w_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_w_valid && !i_w_ready) |=> (i_w_valid && $stable(i_w)))
    else $error("w valid dropped or payload changed before ready");

  ar_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_ar_valid && !i_ar_ready) |=> (i_ar_valid && $stable(i_ar)))
    else $error("ar valid dropped or payload changed before ready");

  // response readies mark the outstanding access
  one_access: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_b_ready && i_r_ready))
    else $error("read and write outstanding at the same time");

  // halt and fault are final states and never overlap
  status_final: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_halted || i_fault) |=>
      ($stable(i_halted) && $stable(i_fault) && !(i_halted && i_fault)))
    else $error("halted or fault changed before reset, or both high");

endmodule

bind cpu_top cpu_bus_assert u_bus_assert (
  .i_clk      (i_clk),
  .i_reset    (i_reset),
  .i_aw_valid (o_aw_valid),
  .i_aw       (o_aw),
  .i_aw_ready (i_aw_ready),
  .i_w_valid  (o_w_valid),
  .i_w        (o_w),
  .i_w_ready  (i_w_ready),
  .i_ar_valid (o_ar_valid),
  .i_ar       (o_ar),
  .i_ar_ready (i_ar_ready),
  .i_b_ready  (o_b_ready),
  .i_r_ready  (o_r_ready),
  .i_halted   (o_halted),
  .i_fault    (o_fault)
);

//--- bench/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ();

  localparam word_t RESET_PC    = 16'h0000;
  localparam int    BUS_TIMEOUT = 64;
  localparam int    BODY_LEN    = 24;
  localparam int    MAX_STEPS   = 200;
  localparam int    RUN_LIMIT   = 20000;

  logic     clk      = 1'b0;
  logic     reset    = 1'b1;
  logic     aw_ready = 1'b0;
  logic     w_ready  = 1'b0;
  logic     ar_ready = 1'b0;
  logic     b_valid  = 1'b0;
  logic     r_valid  = 1'b0;
  axil_b_t  b        = '0;
  axil_r_t  r        = '0;
  logic     aw_valid;
  logic     w_valid;
  logic     ar_valid;
  logic     b_ready;
  logic     r_ready;
  axil_aw_t aw;
  axil_w_t  w;
  axil_ar_t ar;
  logic     halted;
  logic     fault;

  integer   seed;
  word_t    image [256];
  word_t    mem [256];
  word_t    mmem [256];
  word_t    mregs [8];
  axil_aw_t exp_aw_q [$];
  axil_w_t  exp_w_q [$];
  bit       stall_r;

  // slave bookkeeping
  int       ar_wait, r_wait, aw_wait, w_wait, b_wait;
  bit       aw_got, w_got, r_pend, b_pend;
  axil_aw_t aw_hold;
  axil_w_t  w_hold;
  word_t    rd_addr;

  cpu_top #(.RESET_PC(RESET_PC), .BUS_TIMEOUT(BUS_TIMEOUT)) dut (
    .i_clk      (clk),
    .i_reset    (reset),
    .o_aw_valid (aw_valid),
    .o_aw       (aw),
    .i_aw_ready (aw_ready),
    .o_w_valid  (w_valid),
    .o_w        (w),
    .i_w_ready  (w_ready),
    .i_b_valid  (b_valid),
    .i_b        (b),
    .o_b_ready  (b_ready),
    .o_ar_valid (ar_valid),
    .o_ar       (ar),
    .i_ar_ready (ar_ready),
    .i_r_valid  (r_valid),
    .i_r        (r),
    .o_r_ready  (r_ready),
    .o_halted   (halted),
    .o_fault    (fault)
  );

  always #2 clk = ~clk;

  function automatic int unsigned rnd(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // fill for words the program does not use
  function automatic word_t pattern(int a);
    return word_t'(a * 40503) ^ 16'h5a5a;
  endfunction

  function automatic word_t enc(opcode_t op, logic imm, reg_idx_t rx, logic [7:0] up);
    instr_t i;
    i = '0;
    i.op = op;
    i.imm = imm;
    i.rx = rx;
    i.upper.imm8 = up;
    return word_t'(i);
  endfunction

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(word_t got, word_t exp, string name);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_status(logic got, logic exp, string name);
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_write(axil_aw_t got_aw, axil_w_t got_w);
    axil_aw_t e_aw;
    axil_w_t  e_w;
    if (exp_aw_q.size() == 0) begin
      $display("an AXI write arrived at %0t but the model has no store left", $time);
      stop_run();
    end else begin
      e_aw = exp_aw_q.pop_front();
      e_w  = exp_w_q.pop_front();
      if (got_aw !== e_aw) begin
        $display("FAIL %0t o_aw got %h expected %h", $time, got_aw, e_aw);
        stop_run();
      end else if (got_w !== e_w) begin
        $display("FAIL %0t o_w got %h expected %h", $time, got_w, e_w);
        stop_run();
      end
    end
  endtask

  // AXI4-Lite slave with random ready and valid delays
  always @(posedge clk) begin
    if (reset) begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      ar_ready <= 1'b0;
      b_valid  <= 1'b0;
      r_valid  <= 1'b0;
      aw_got = 0;
      w_got  = 0;
      r_pend = 0;
      b_pend = 0;
      ar_wait = rnd(4);
      aw_wait = rnd(4);
      w_wait  = rnd(4);
    end else begin
      if (ar_valid && ar_ready) begin
        ar_ready <= 1'b0;
        rd_addr = ar.addr;
        r_pend  = 1;
        r_wait  = rnd(4);
        ar_wait = rnd(4);
      end else if (ar_valid) begin
        if (ar_wait == 0) ar_ready <= 1'b1;
        else ar_wait--;
      end
      if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end else if (r_pend && !r_valid && !stall_r) begin
        if (r_wait == 0) begin
          r_valid <= 1'b1;
          r <= '{data: mem[rd_addr[8:1]], resp: 2'b00};
          r_pend = 0;
        end else begin
          r_wait--;
        end
      end
      if (aw_valid && aw_ready) begin
        aw_ready <= 1'b0;
        aw_hold = aw;
        aw_got  = 1;
        aw_wait = rnd(4);
      end else if (aw_valid && !aw_got) begin
        if (aw_wait == 0) aw_ready <= 1'b1;
        else aw_wait--;
      end
      if (w_valid && w_ready) begin
        w_ready <= 1'b0;
        w_hold = w;
        w_got  = 1;
        w_wait = rnd(4);
      end else if (w_valid && !w_got) begin
        if (w_wait == 0) w_ready <= 1'b1;
        else w_wait--;
      end
      if (aw_got && w_got && !b_pend) begin
        check_write(aw_hold, w_hold);
        mem[aw_hold.addr[8:1]] = w_hold.data;
        aw_got = 0;
        w_got  = 0;
        b_pend = 1;
        b_wait = rnd(4);
      end
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end else if (b_pend && !b_valid) begin
        if (b_wait == 0) begin
          b_valid <= 1'b1;
          b <= '{resp: 2'b00};
          b_pend = 0;
        end else begin
          b_wait--;
        end
      end
    end
  end

  // instruction set model, also fills the expected write queue
  task automatic run_model(output bit ok);
    word_t pc, ins, b_op, sx, res, rxv, ryv;
    reg_idx_t rx, ry;
    int steps;
    bit n, z, done;
    exp_aw_q.delete();
    exp_w_q.delete();
    for (int a = 0; a < 256; a++) mmem[a] = image[a];
    for (int i = 0; i < 8; i++) mregs[i] = '0;
    pc = RESET_PC;
    n = 0;
    z = 0;
    done = 0;
    steps = 0;
    while (!done && steps < MAX_STEPS) begin
      ins = mmem[pc[7:0]];
      pc  = pc + 16'd1;
      steps++;
      rx   = ins[7:5];
      ry   = ins[10:8];
      sx   = {{8{ins[15]}}, ins[15:8]};
      rxv  = mregs[rx];
      ryv  = mregs[ry];
      b_op = ins[4] ? sx : ryv;
      case (ins[3:0])
        OP_MV: mregs[rx] = b_op;
        OP_ADD, OP_SUB, OP_CMP: begin
          res = (ins[3:0] == OP_ADD) ? rxv + b_op : rxv - b_op;
          n = res[15];
          z = (res == '0);
          if (ins[3:0] != OP_CMP) mregs[rx] = res;
        end
        OP_LD: mregs[rx] = mmem[ryv[7:0]];
        OP_ST: begin
          mmem[ryv[7:0]] = rxv;
          exp_aw_q.push_back('{addr: word_t'(ryv * 2), prot: 3'b000});
          exp_w_q.push_back('{data: rxv, strb: 2'b11});
        end
        OP_MVHI: mregs[rx] = {ins[15:8], rxv[7:0]};
        OP_HALT: done = 1;
        OP_J: pc = ins[4] ? pc + sx : ryv;
        OP_JZ: if (z) pc = ins[4] ? pc + sx : ryv;
        OP_JN: if (n) pc = ins[4] ? pc + sx : ryv;
        OP_CALL: begin
          mregs[7] = pc;
          pc = ins[4] ? pc + sx : ryv;
        end
        default: begin
        end
      endcase
    end
    ok = done;
  endtask

  task automatic gen_program(bit rich);
    int pc, kind, k, lim;
    reg_idx_t rx, ry;
    opcode_t jop;
    logic [7:0] v;
    for (int a = 0; a < 256; a++) image[a] = pattern(a);
    pc = 0;
    while (pc < BODY_LEN) begin
      rx = reg_idx_t'(rnd(8));
      ry = reg_idx_t'(rnd(8));
      v  = 8'(rnd(256));
      case (rnd(4))
        0: jop = OP_J;
        1: jop = OP_JZ;
        2: jop = OP_JN;
        default: jop = OP_CALL;
      endcase
      kind = int'(rnd(10));
      if (rich && rnd(2) == 0) kind = (rnd(3) == 0) ? 4 : ((rnd(2) == 0) ? 8 : 9);
      case (kind)
        0: image[pc] = enc(OP_MV, 1'b1, rx, v);
        1: image[pc] = enc(OP_MV, 1'b0, rx, {5'b0, ry});
        2: image[pc] = rnd(2) ? enc(OP_ADD, 1'b1, rx, v) : enc(OP_ADD, 1'b0, rx, {5'b0, ry});
        3: image[pc] = rnd(2) ? enc(OP_SUB, 1'b1, rx, v) : enc(OP_SUB, 1'b0, rx, {5'b0, ry});
        4: image[pc] = rnd(2) ? enc(OP_CMP, 1'b1, rx, v) : enc(OP_CMP, 1'b0, rx, {5'b0, ry});
        5: image[pc] = enc(OP_MVHI, 1'b1, rx, v);
        6: image[pc] = enc(OP_LD, 1'b0, rx, {5'b0, ry});
        7: image[pc] = enc(OP_ST, 1'b0, rx, {5'b0, ry});
        8: begin
          // forward offset, never past the register dump
          lim = BODY_LEN - (pc + 1);
          k = (lim > 3) ? int'(rnd(4)) : int'(rnd(lim + 1));
          image[pc] = enc(jop, 1'b1, rx, 8'(k));
        end
        default: begin
          if (pc + 2 <= BODY_LEN) begin
            k = int'(rnd(BODY_LEN - (pc + 2) + 1));
            image[pc] = enc(OP_MV, 1'b1, ry, 8'(pc + 2 + k));
            pc++;
            image[pc] = enc(jop, 1'b0, rx, {5'b0, ry});
          end else begin
            image[pc] = enc(OP_MV, 1'b0, rx, {5'b0, ry});
          end
        end
      endcase
      pc++;
    end
    // dump r7 through r6 to words 240 to 247
    image[pc] = enc(OP_MV, 1'b1, 3'd6, 8'd247);
    image[pc + 1] = enc(OP_ST, 1'b0, 3'd7, 8'd6);
    pc += 2;
    for (int i = 0; i < 7; i++) begin
      image[pc] = enc(OP_MV, 1'b1, 3'd7, 8'(240 + i));
      image[pc + 1] = enc(OP_ST, 1'b0, reg_idx_t'(i), 8'd7);
      pc += 2;
    end
    image[pc] = enc(OP_HALT, 1'b0, 3'd0, 8'd0);
  endtask

  task automatic make_program(bit rich);
    int tries;
    bit ok;
    tries = 0;
    ok = 0;
    while (!ok && tries < 50) begin
      gen_program(rich);
      run_model(ok);
      tries++;
    end
    if (!ok) begin
      $display("no generated program reached halt within %0d instructions", MAX_STEPS);
      stop_run();
    end
  endtask

  task automatic start_run(bit fresh, bit rich);
    bit ok;
    reset <= 1'b1;
    @(posedge clk);
    if (fresh) make_program(rich);
    else run_model(ok);
    for (int a = 0; a < 256; a++) mem[a] = image[a];
    repeat (3) @(posedge clk);
    check_status(aw_valid, 1'b0, "o_aw_valid");
    check_status(w_valid, 1'b0, "o_w_valid");
    check_status(ar_valid, 1'b0, "o_ar_valid");
    check_status(b_ready, 1'b0, "o_b_ready");
    check_status(r_ready, 1'b0, "o_r_ready");
    check_status(halted, 1'b0, "o_halted");
    check_status(fault, 1'b0, "o_fault");
    reset <= 1'b0;
  endtask

  task automatic wait_halted(int limit);
    int n;
    n = 0;
    while (!halted && !fault && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (fault) begin
      $display("core entered the fault state while running a program");
      stop_run();
    end else if (!halted) begin
      $display("timeout, o_halted did not rise within %0d cycles", limit);
      stop_run();
    end
  endtask

  task automatic wait_fault(int limit);
    int n;
    n = 0;
    while (!fault && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!fault) begin
      $display("timeout, o_fault did not rise within %0d cycles", limit);
      stop_run();
    end
  endtask

  task automatic wait_ar(int limit);
    int n;
    n = 0;
    while (!ar_valid && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!ar_valid) begin
      $display("timeout, no fetch request within %0d cycles after reset", limit);
      stop_run();
    end
  endtask

  // core must stay quiet in halt or fault
  task automatic idle_check(int cycles, logic exp_halted, logic exp_fault);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      check_status(aw_valid || w_valid || ar_valid, 1'b0, "any request valid");
      check_status(halted, exp_halted, "o_halted");
      check_status(fault, exp_fault, "o_fault");
    end
  endtask

  task automatic check_results();
    check_word(word_t'(exp_aw_q.size()), 16'd0, "stores left in model");
    for (int a = 240; a < 248; a++) begin
      check_word(mem[a], mmem[a], $sformatf("mem[%0d]", a));
    end
  endtask

  initial begin
    seed = 32'h2708;
    stall_r = 0;
    for (int p = 0; p < 20; p++) begin
      start_run(1'b1, p >= 10);
      wait_halted(RUN_LIMIT);
      check_results();
      idle_check(50, 1'b1, 1'b0);
    end

    // read data withheld past the timer limit
    stall_r = 1;
    start_run(1'b1, 1'b0);
    wait_fault(BUS_TIMEOUT * 4 + 50);
    idle_check(50, 1'b0, 1'b1);
    stall_r = 0;

    // reset in the middle of a program, then a clean rerun
    start_run(1'b1, 1'b0);
    repeat (60) @(posedge clk);
    start_run(1'b0, 1'b0);
    wait_ar(100);
    check_word(ar.addr, word_t'(RESET_PC * 2), "o_ar.addr");
    wait_halted(RUN_LIMIT);
    check_results();
    idle_check(50, 1'b1, 1'b0);

    $display("No errors");
    $finish;
  end

endmodule

//--- sim.f
source/cpu_pkg.sv
source/cpu_alu.sv
source/axil_channel.sv
source/axil_master.sv
source/bus_timer.sv
source/cpu_control.sv
source/cpu_datapath.sv
source/cpu_top.sv
bench/cpu_bus_assert.sv
bench/tb_cpu.sv

//--- source/axil_channel.sv
`timescale 1ns/10ps

module axil_channel #(
  parameter type payload_t = logic [15:0]
) (
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_load,
  input  payload_t i_payload,
  input  logic     i_ready,
  output logic     o_valid,
  output payload_t o_payload
);

  // valid drops after the handshake edge
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (i_load) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      o_payload <= i_payload;
    end
  end

endmodule

//--- source/axil_master.sv
`timescale 1ns/10ps

module axil_master import cpu_pkg::*; (
  input  logic     i_clk,
  input  logic     i_reset,
  input  mem_req_t i_req,
  output logic     o_done,
  output word_t    o_rdata,
  output logic     o_aw_valid,
  output axil_aw_t o_aw,
  input  logic     i_aw_ready,
  output logic     o_w_valid,
  output axil_w_t  o_w,
  input  logic     i_w_ready,
  input  logic     i_b_valid,
  input  axil_b_t  i_b,
  output logic     o_b_ready,
  output logic     o_ar_valid,
  output axil_ar_t o_ar,
  input  logic     i_ar_ready,
  input  logic     i_r_valid,
  input  axil_r_t  i_r,
  output logic     o_r_ready
);

  logic     wr_pend;
  logic     rd_pend;
  logic     b_fire;
  logic     r_fire;
  word_t    byte_addr;
  axil_aw_t aw_req;
  axil_w_t  w_req;
  axil_ar_t ar_req;

  // word address to byte address, prot is plain data access
  assign byte_addr = {i_req.addr[14:0], 1'b0};
  assign aw_req    = '{addr: byte_addr, prot: 3'b000};
  assign ar_req    = '{addr: byte_addr, prot: 3'b000};
  assign w_req     = '{data: i_req.wdata, strb: 2'b11};

  axil_channel #(.payload_t(axil_aw_t)) u_aw (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_load    (i_req.write),
    .i_payload (aw_req),
    .i_ready   (i_aw_ready),
    .o_valid   (o_aw_valid),
    .o_payload (o_aw)
  );

  axil_channel #(.payload_t(axil_w_t)) u_w (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_load    (i_req.write),
    .i_payload (w_req),
    .i_ready   (i_w_ready),
    .o_valid   (o_w_valid),
    .o_payload (o_w)
  );

  axil_channel #(.payload_t(axil_ar_t)) u_ar (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_load    (i_req.read),
    .i_payload (ar_req),
    .i_ready   (i_ar_ready),
    .o_valid   (o_ar_valid),
    .o_payload (o_ar)
  );

  // response channels open only while a request is outstanding
  assign o_b_ready = wr_pend;
  assign o_r_ready = rd_pend;
  assign b_fire    = i_b_valid && o_b_ready;
  assign r_fire    = i_r_valid && o_r_ready;

  // any response code completes the access, i_b.resp and i_r.resp are not inspected
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      wr_pend <= 1'b0;
      rd_pend <= 1'b0;
      o_done  <= 1'b0;
    end else begin
      if (i_req.write) begin
        wr_pend <= 1'b1;
      end else if (b_fire) begin
        wr_pend <= 1'b0;
      end
      if (i_req.read) begin
        rd_pend <= 1'b1;
      end else if (r_fire) begin
        rd_pend <= 1'b0;
      end
      o_done <= b_fire || r_fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_fire) begin
      o_rdata <= i_r.data;
    end
  end

endmodule

//--- source/bus_timer.sv
`timescale 1ns/10ps

module bus_timer #(
  parameter int BUS_TIMEOUT = 64
) (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_active,
  output logic o_timeout
);

  localparam int CW = $clog2(BUS_TIMEOUT + 1);

  logic [CW-1:0] count;

  // saturates at the limit so the flag holds until the wait ends
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      count <= '0;
    end else if (!i_active) begin
      count <= '0;
    end else if (count != CW'(BUS_TIMEOUT)) begin
      count <= count + 1'b1;
    end
  end

  assign o_timeout = (count == CW'(BUS_TIMEOUT));

endmodule

//--- source/cpu_alu.sv
`timescale 1ns/10ps

module cpu_alu import cpu_pkg::*; (
  input  alu_op_t i_op,
  input  word_t   i_a,
  input  word_t   i_b,
  output word_t   o_result,
  output logic    o_n,
  output logic    o_z
);

  always_comb begin
    case (i_op)
      ALU_ADD: begin
        o_result = i_a + i_b;
      end
      ALU_SUB: begin
        o_result = i_a - i_b;
      end
      // mvhi, low byte of b replaces the upper byte of a
      ALU_MERGE_HI: begin
        o_result = {i_b[7:0], i_a[7:0]};
      end
      default: begin
        o_result = i_b;
      end
    endcase
  end

  assign o_n = o_result[15];
  assign o_z = (o_result == '0);

endmodule

//--- source/cpu_control.sv
`timescale 1ns/10ps

module cpu_control import cpu_pkg::*; (
  input  logic   i_clk,
  input  logic   i_reset,
  input  instr_t i_instr,
  input  logic   i_flag_n,
  input  logic   i_flag_z,
  input  logic   i_mem_done,
  input  logic   i_timeout,
  output ctrl_t  o_ctrl,
  output logic   o_mem_rd,
  output logic   o_mem_wr,
  output logic   o_bus_wait,
  output logic   o_halted,
  output logic   o_fault
);

  typedef enum logic [2:0] {
    S_FETCH,
    S_FETCH_WAIT,
    S_EXECUTE,
    S_MEM,
    S_MEM_WAIT,
    S_HALT,
    S_FAULT
  } state_t;

  state_t state, next_state;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      state <= S_FETCH;
    end else begin
      state <= next_state;
    end
  end

  assign o_bus_wait = (state == S_FETCH_WAIT) || (state == S_MEM_WAIT);
  assign o_halted   = (state == S_HALT);
  assign o_fault    = (state == S_FAULT);

  always_comb begin
    next_state = state;
    o_ctrl     = '0;
    o_mem_rd   = 1'b0;
    o_mem_wr   = 1'b0;

    case (state)
      S_FETCH: begin
        o_mem_rd          = 1'b1;
        o_ctrl.addr_sel   = ADDR_PC;
        // a finished ld writes its data back while the next fetch goes out
        if (i_instr.op == OP_LD) begin
          o_ctrl.rf_write = 1'b1;
          o_ctrl.rf_sel   = RF_MEM;
        end
        next_state = S_FETCH_WAIT;
      end

      S_FETCH_WAIT: begin
        if (i_mem_done) begin
          o_ctrl.ir_ld  = 1'b1;
          o_ctrl.pc_ld  = 1'b1;
          o_ctrl.pc_sel = PC_INC;
          next_state    = S_EXECUTE;
        end else if (i_timeout) begin
          next_state = S_FAULT;
        end
      end

      S_EXECUTE: begin
        next_state       = S_FETCH;
        o_ctrl.alu_b_sel = i_instr.imm ? B_IMM : B_RY;
        o_ctrl.pc_sel    = i_instr.imm ? PC_REL : PC_REG;
        case (i_instr.op)
          OP_MV: begin
            o_ctrl.alu_op   = ALU_PASS_B;
            o_ctrl.rf_write = 1'b1;
          end
          OP_ADD: begin
            o_ctrl.alu_op   = ALU_ADD;
            o_ctrl.rf_write = 1'b1;
            o_ctrl.flags_ld = 1'b1;
          end
          OP_SUB: begin
            o_ctrl.alu_op   = ALU_SUB;
            o_ctrl.rf_write = 1'b1;
            o_ctrl.flags_ld = 1'b1;
          end
          // flags only
          OP_CMP: begin
            o_ctrl.alu_op   = ALU_SUB;
            o_ctrl.flags_ld = 1'b1;
          end
          OP_LD, OP_ST: begin
            next_state = S_MEM;
          end
          OP_MVHI: begin
            o_ctrl.alu_b_sel = B_IMM;
            o_ctrl.alu_op    = ALU_MERGE_HI;
            o_ctrl.rf_write  = 1'b1;
          end
          OP_HALT: begin
            next_state = S_HALT;
          end
          OP_J: begin
            o_ctrl.pc_ld = 1'b1;
          end
          OP_JZ: begin
            o_ctrl.pc_ld = i_flag_z;
          end
          OP_JN: begin
            o_ctrl.pc_ld = i_flag_n;
          end
          // return address is the already incremented pc
          OP_CALL: begin
            o_ctrl.pc_ld        = 1'b1;
            o_ctrl.rf_write     = 1'b1;
            o_ctrl.rf_sel       = RF_PC;
            o_ctrl.rf_waddr_sel = WA_R7;
          end
          default: begin
          end
        endcase
      end

      S_MEM: begin
        o_ctrl.addr_sel = ADDR_RY;
        o_mem_rd        = (i_instr.op == OP_LD);
        o_mem_wr        = (i_instr.op == OP_ST);
        next_state      = S_MEM_WAIT;
      end

      S_MEM_WAIT: begin
        if (i_mem_done) begin
          next_state = S_FETCH;
        end else if (i_timeout) begin
          next_state = S_FAULT;
        end
      end

      default: begin
      end
    endcase
  end

endmodule

//--- source/cpu_datapath.sv
`timescale 1ns/10ps

module cpu_datapath import cpu_pkg::*; #(
  parameter word_t RESET_PC = 16'h0000
) (
  input  logic   i_clk,
  input  logic   i_reset,
  input  ctrl_t  i_ctrl,
  input  word_t  i_rdata,
  input  logic   i_rdata_valid,
  output instr_t o_instr,
  output word_t  o_addr,
  output word_t  o_wdata,
  output logic   o_flag_n,
  output logic   o_flag_z
);

  word_t    pc;
  instr_t   ir;
  word_t    rf [8];
  word_t    mdr;
  word_t    imm_sext;
  word_t    rx_val;
  word_t    ry_val;
  word_t    alu_b;
  word_t    alu_result;
  word_t    wb_data;
  word_t    pc_next;
  reg_idx_t waddr;
  logic     alu_n;
  logic     alu_z;

  assign imm_sext = {{8{ir.upper.imm8[7]}}, ir.upper.imm8};
  assign rx_val   = rf[ir.rx];
  assign ry_val   = rf[ir.upper.r.ry];
  assign alu_b    = (i_ctrl.alu_b_sel == B_IMM) ? imm_sext : ry_val;

  cpu_alu u_alu (
    .i_op     (i_ctrl.alu_op),
    .i_a      (rx_val),
    .i_b      (alu_b),
    .o_result (alu_result),
    .o_n      (alu_n),
    .o_z      (alu_z)
  );

  always_comb begin
    case (i_ctrl.rf_sel)
      RF_MEM:  wb_data = mdr;
      RF_PC:   wb_data = pc;
      default: wb_data = alu_result;
    endcase
  end

  // relative jumps count from the incremented pc
  always_comb begin
    case (i_ctrl.pc_sel)
      PC_REL:  pc_next = pc + imm_sext;
      PC_REG:  pc_next = ry_val;
      default: pc_next = pc + 16'd1;
    endcase
  end

  assign waddr = (i_ctrl.rf_waddr_sel == WA_R7) ? 3'd7 : ir.rx;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      pc       <= RESET_PC;
      ir       <= '0;
      o_flag_n <= 1'b0;
      o_flag_z <= 1'b0;
      // registers start at zero
      for (int i = 0; i < 8; i++) begin
        rf[i] <= '0;
      end
    end else begin
      if (i_ctrl.pc_ld) begin
        pc <= pc_next;
      end
      if (i_ctrl.ir_ld) begin
        ir <= instr_t'(i_rdata);
      end
      if (i_ctrl.flags_ld) begin
        o_flag_n <= alu_n;
        o_flag_z <= alu_z;
      end
      if (i_ctrl.rf_write) begin
        rf[waddr] <= wb_data;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rdata_valid) begin
      mdr <= i_rdata;
    end
  end

  assign o_instr = ir;
  assign o_addr  = (i_ctrl.addr_sel == ADDR_RY) ? ry_val : pc;
  assign o_wdata = rx_val;

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_idx_t;

  // opcode field, bit 4 of the word sits above it as the immediate flag
  typedef enum logic [3:0] {
    OP_MV   = 4'b0000,
    OP_ADD  = 4'b0001,
    OP_SUB  = 4'b0010,
    OP_CMP  = 4'b0011,
    OP_LD   = 4'b0100,
    OP_ST   = 4'b0101,
    OP_MVHI = 4'b0110,
    OP_HALT = 4'b0111,
    OP_J    = 4'b1000,
    OP_JZ   = 4'b1001,
    OP_JN   = 4'b1010,
    OP_CALL = 4'b1100
  } opcode_t;

  // upper byte is ry in register forms, imm8 in immediate forms
  typedef union packed {
    struct packed {
      logic [4:0] spare;
      reg_idx_t   ry;
    } r;
    logic [7:0] imm8;
  } instr_upper_t;

  typedef struct packed {
    instr_upper_t upper;
    reg_idx_t     rx;
    logic         imm;
    opcode_t      op;
  } instr_t;

  typedef enum logic       {ADDR_PC, ADDR_RY} addr_sel_t;
  typedef enum logic [1:0] {PC_INC, PC_REL, PC_REG} pc_sel_t;
  typedef enum logic [1:0] {RF_ALU, RF_MEM, RF_PC} rf_sel_t;
  typedef enum logic       {WA_RX, WA_R7} waddr_sel_t;
  typedef enum logic       {B_RY, B_IMM} b_sel_t;
  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_PASS_B, ALU_MERGE_HI} alu_op_t;

  typedef struct packed {
    addr_sel_t  addr_sel;
    pc_sel_t    pc_sel;
    logic       pc_ld;
    logic       ir_ld;
    rf_sel_t    rf_sel;
    logic       rf_write;
    waddr_sel_t rf_waddr_sel;
    logic       flags_ld;
    b_sel_t     alu_b_sel;
    alu_op_t    alu_op;
  } ctrl_t;

  // addr is a word address
  typedef struct packed {
    logic  read;
    logic  write;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [2:0]  prot;
  } axil_aw_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [2:0]  prot;
  } axil_ar_t;

  typedef struct packed {
    logic [15:0] data;
    logic [1:0]  strb;
  } axil_w_t;

  typedef struct packed {
    logic [15:0] data;
    logic [1:0]  resp;
  } axil_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

endpackage

//--- source/cpu_top.sv
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; #(
  parameter word_t RESET_PC    = 16'h0000,
  parameter int    BUS_TIMEOUT = 64
) (
  input  logic     i_clk,
  input  logic     i_reset,
  output logic     o_aw_valid,
  output axil_aw_t o_aw,
  input  logic     i_aw_ready,
  output logic     o_w_valid,
  output axil_w_t  o_w,
  input  logic     i_w_ready,
  input  logic     i_b_valid,
  input  axil_b_t  i_b,
  output logic     o_b_ready,
  output logic     o_ar_valid,
  output axil_ar_t o_ar,
  input  logic     i_ar_ready,
  input  logic     i_r_valid,
  input  axil_r_t  i_r,
  output logic     o_r_ready,
  output logic     o_halted,
  output logic     o_fault
);

  ctrl_t  ctrl;
  instr_t instr;
  logic   flag_n;
  logic   flag_z;
  logic   mem_rd;
  logic   mem_wr;
  logic   mem_done;
  logic   bus_wait;
  logic   timeout;
  word_t  mem_addr;
  word_t  mem_wdata;
  word_t  mem_rdata;

  cpu_control u_control (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_instr    (instr),
    .i_flag_n   (flag_n),
    .i_flag_z   (flag_z),
    .i_mem_done (mem_done),
    .i_timeout  (timeout),
    .o_ctrl     (ctrl),
    .o_mem_rd   (mem_rd),
    .o_mem_wr   (mem_wr),
    .o_bus_wait (bus_wait),
    .o_halted   (o_halted),
    .o_fault    (o_fault)
  );

  bus_timer #(.BUS_TIMEOUT(BUS_TIMEOUT)) u_timer (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_active  (bus_wait),
    .o_timeout (timeout)
  );

  cpu_datapath #(.RESET_PC(RESET_PC)) u_datapath (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_ctrl        (ctrl),
    .i_rdata       (mem_rdata),
    .i_rdata_valid (mem_done),
    .o_instr       (instr),
    .o_addr        (mem_addr),
    .o_wdata       (mem_wdata),
    .o_flag_n      (flag_n),
    .o_flag_z      (flag_z)
  );

  // request packs as read, write, word address, write data
  axil_master u_master (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_req      ({mem_rd, mem_wr, mem_addr, mem_wdata}),
    .o_done     (mem_done),
    .o_rdata    (mem_rdata),
    .o_aw_valid (o_aw_valid),
    .o_aw       (o_aw),
    .i_aw_ready (i_aw_ready),
    .o_w_valid  (o_w_valid),
    .o_w        (o_w),
    .i_w_ready  (i_w_ready),
    .i_b_valid  (i_b_valid),
    .i_b        (i_b),
    .o_b_ready  (o_b_ready),
    .o_ar_valid (o_ar_valid),
    .o_ar       (o_ar),
    .i_ar_ready (i_ar_ready),
    .i_r_valid  (i_r_valid),
    .i_r        (i_r),
    .o_r_ready  (o_r_ready)
  );

endmodule
